/* logic/motor_pkg.sv */
`default_nettype none

package motor_pkg;

  typedef logic [3:0] coil_t;         // Bit 3 down to 0 is a1, a2, b1, b2
  typedef logic [2:0] phase_index_t;  // Electrical position in half steps
  typedef logic [2:0] microstep_t;    // Host mode select

  localparam microstep_t MODE_FULL     = 3'd0;
  localparam microstep_t MODE_FULL_ALT = 3'd1;  // Same sequence as mode 0
  localparam microstep_t MODE_HALF     = 3'd2;  // Anything above holds

  localparam int COIL_A1 = 3;
  localparam int COIL_A2 = 2;
  localparam int COIL_B1 = 1;
  localparam int COIL_B2 = 0;

  // Even entries drive both windings, odd entries only one
  localparam coil_t PHASE_TABLE [8] = '{
    4'b1010,
    4'b0010,
    4'b0110,
    4'b0100,
    4'b0101,
    4'b0001,
    4'b1001,
    4'b1000
  };

endpackage

`default_nettype wire

/* logic/move_pkg.sv */
`default_nettype none

package move_pkg;

  // Move sequencing states
  typedef enum logic [1:0] {
    IDLE,    // Waiting for a start strobe
    RUN,     // Ticks being counted
    FINISH   // One-cycle completion slot
  } move_state_t;

  // Width of the requested step count
  localparam int DEFAULT_STEPS_WIDTH = 16;

  // Width of the step period in clock cycles
  localparam int DEFAULT_PERIOD_WIDTH = 16;

  // Shortest period the timer can space ticks at
  localparam int MIN_STEP_PERIOD = 2;

endpackage

`default_nettype wire

/* logic/move_control.sv */
`default_nettype none

module move_control import move_pkg::*, motor_pkg::*; #(
  parameter int STEPS_WIDTH  = DEFAULT_STEPS_WIDTH,
  parameter int PERIOD_WIDTH = DEFAULT_PERIOD_WIDTH
) (
  input  wire                    step,
  input  wire                    reset,
  input  wire                    move_start,
  input  wire [STEPS_WIDTH-1:0]  move_steps,
  input  wire [PERIOD_WIDTH-1:0] move_period,
  input  wire                    move_dir,
  input  wire microstep_t        microsteps,
  input  wire                    hold,
  input  wire                    step_tick,
  output logic                   move_busy,
  output logic                   move_done,
  output logic                   timer_run,
  output logic                   timer_load,
  output logic [PERIOD_WIDTH-1:0] timer_period,
  output logic                   energize,
  output logic                   run_dir,
  output microstep_t             run_mode
);

  typedef logic [STEPS_WIDTH-1:0]  steps_t;
  typedef logic [PERIOD_WIDTH-1:0] period_t;

  localparam period_t MIN_PERIOD = period_t'(MIN_STEP_PERIOD);

  move_state_t state;
  steps_t      steps_left;   // Ticks still to come
  period_t     period_q;     // Clamped period of the running move
  period_t     period_in;
  logic        start_ok;

  assign start_ok  = move_start && (state != RUN);  // Dropped while busy
  assign period_in = (move_period < MIN_PERIOD) ? MIN_PERIOD : move_period;

  always_ff @(posedge step) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE, FINISH: begin
          if (start_ok) begin
            // A zero-step move goes straight to completion
            state <= (move_steps == '0) ? FINISH : RUN;
          end else begin
            state <= IDLE;
          end
        end
        RUN: begin
          if (step_tick && (steps_left == steps_t'(1))) begin
            state <= FINISH;  // Last tick seen
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge step) begin
    if (start_ok) begin
      steps_left <= move_steps;
      period_q   <= period_in;
      run_dir    <= move_dir;
      run_mode   <= microsteps;
    end else if ((state == RUN) && step_tick) begin
      steps_left <= steps_left - steps_t'(1);
    end
  end

  assign move_busy  = (state == RUN);
  assign move_done  = (state == FINISH);
  assign timer_run  = (state == RUN);
  assign timer_load = start_ok;

  // Start cycle loads straight from the host inputs
  assign timer_period = (state == RUN) ? period_q : period_in;

  assign energize = (state == RUN) || hold;

endmodule

`default_nettype wire

/* logic/step_timer.sv */
`default_nettype none

module step_timer import move_pkg::*; #(
  parameter int PERIOD_WIDTH = DEFAULT_PERIOD_WIDTH
) (
  input  wire                    step,
  input  wire                    reset,
  input  wire                    timer_run,
  input  wire                    timer_load,
  input  wire [PERIOD_WIDTH-1:0] timer_period,
  output logic                   step_tick
);

  typedef logic [PERIOD_WIDTH-1:0] period_t;

  period_t count;   // Cycles left before the next tick
  period_t reload;

  // Counting down to zero takes one cycle more than the load value
  assign reload = timer_period - period_t'(1);

  assign step_tick = timer_run && (count == '0);

  always_ff @(posedge step) begin
    if (reset) begin
      count <= '0;
    end else if (timer_load) begin
      count <= reload;  // Start of a move
    end else if (timer_run) begin
      if (count == '0) begin
        count <= reload;  // Tick issued this cycle
      end else begin
        count <= count - period_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/dual_hbridge.sv */
`default_nettype none

module dual_hbridge import motor_pkg::*; (
  input  wire        step,
  input  wire        reset,
  input  wire        step_tick,
  input  wire        energize,
  input  wire        run_dir,
  input  wire microstep_t run_mode,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       pwm_a,
  output logic       pwm_b
);

  phase_index_t index;       // Current electrical position
  phase_index_t next_index;
  phase_index_t full_move;
  phase_index_t half_move;
  coil_t        pattern;     // Table entry for index
  coil_t        coils;

  // Wraps modulo 8 through the 3-bit width
  assign half_move = run_dir ? (index + phase_index_t'(1))
                             : (index - phase_index_t'(1));
  assign full_move = run_dir ? (index + phase_index_t'(2))
                             : (index - phase_index_t'(2));

  always_comb begin
    case (run_mode)
      MODE_FULL, MODE_FULL_ALT: begin
        next_index = {full_move[2:1], 1'b0};  // Snap to a two-coil entry
      end
      MODE_HALF: begin
        next_index = half_move;
      end
      default: begin
        next_index = index;  // Hold modes
      end
    endcase
  end

  always_ff @(posedge step) begin
    if (reset) begin
      index   <= '0;
      pattern <= PHASE_TABLE[0];
    end else if (step_tick) begin
      index   <= next_index;
      pattern <= PHASE_TABLE[next_index];
    end
  end

  assign coils = energize ? pattern : '0;  // Bridges off when idle

  assign phase_a1 = coils[COIL_A1];
  assign phase_a2 = coils[COIL_A2];
  assign phase_b1 = coils[COIL_B1];
  assign phase_b2 = coils[COIL_B2];

  // Bridge enable follows whichever winding end is driven
  assign pwm_a = coils[COIL_A1] | coils[COIL_A2];
  assign pwm_b = coils[COIL_B1] | coils[COIL_B2];

endmodule

`default_nettype wire

/* logic/stepper_axis.sv */
`default_nettype none

module stepper_axis import move_pkg::*, motor_pkg::*; #(
  parameter int STEPS_WIDTH  = DEFAULT_STEPS_WIDTH,
  parameter int PERIOD_WIDTH = DEFAULT_PERIOD_WIDTH
) (
  input  wire                    step,
  input  wire                    reset,
  input  wire                    move_start,
  input  wire [STEPS_WIDTH-1:0]  move_steps,
  input  wire [PERIOD_WIDTH-1:0] move_period,
  input  wire                    move_dir,
  input  wire microstep_t        microsteps,
  input  wire                    hold,
  output logic                   move_busy,
  output logic                   move_done,
  output logic                   step_out,
  output logic                   phase_a1,
  output logic                   phase_a2,
  output logic                   phase_b1,
  output logic                   phase_b2,
  output logic                   pwm_a,
  output logic                   pwm_b
);

  logic                    timer_run;
  logic                    timer_load;
  logic [PERIOD_WIDTH-1:0] timer_period;
  logic                    step_tick;
  logic                    energize;
  logic                    run_dir;
  microstep_t              run_mode;

  move_control #(
    .STEPS_WIDTH  (STEPS_WIDTH),
    .PERIOD_WIDTH (PERIOD_WIDTH)
  ) move_control_inst (
    .step         (step),
    .reset        (reset),
    .move_start   (move_start),
    .move_steps   (move_steps),
    .move_period  (move_period),
    .move_dir     (move_dir),
    .microsteps   (microsteps),
    .hold         (hold),
    .step_tick    (step_tick),
    .move_busy    (move_busy),
    .move_done    (move_done),
    .timer_run    (timer_run),
    .timer_load   (timer_load),
    .timer_period (timer_period),
    .energize     (energize),
    .run_dir      (run_dir),
    .run_mode     (run_mode)
  );

  step_timer #(
    .PERIOD_WIDTH (PERIOD_WIDTH)
  ) step_timer_inst (
    .step         (step),
    .reset        (reset),
    .timer_run    (timer_run),
    .timer_load   (timer_load),
    .timer_period (timer_period),
    .step_tick    (step_tick)
  );

  dual_hbridge dual_hbridge_inst (
    .step      (step),
    .reset     (reset),
    .step_tick (step_tick),
    .energize  (energize),
    .run_dir   (run_dir),
    .run_mode  (run_mode),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .pwm_a     (pwm_a),
    .pwm_b     (pwm_b)
  );

  assign step_out = step_tick;  // Step pulse for an external driver

endmodule

`default_nettype wire

/* sim/stepper_axis_assert.sv */
`default_nettype none

module stepper_axis_assert import motor_pkg::*; #(
  parameter int STEPS_WIDTH  = 16,
  parameter int PERIOD_WIDTH = 16
) (
  input  wire                    step,
  input  wire                    reset,
  input  wire                    move_start,
  input  wire [STEPS_WIDTH-1:0]  move_steps,
  input  wire [PERIOD_WIDTH-1:0] move_period,
  input  wire                    move_dir,
  input  wire microstep_t        microsteps,
  input  wire                    hold,
  input  wire                    move_busy,
  input  wire                    move_done,
  input  wire                    step_out,
  input  wire                    phase_a1,
  input  wire                    phase_a2,
  input  wire                    phase_b1,
  input  wire                    phase_b2,
  input  wire                    pwm_a,
  input  wire                    pwm_b
);

  // One entry per half step in coil order a1 a2 b1 b2
  localparam coil_t EXPECTED_COILS [8] = '{
    4'b1010, 4'b0010, 4'b0110, 4'b0100, 4'b0101, 4'b0001, 4'b1001, 4'b1000
  };

  logic                    start_taken;
  logic                    tick_due;     // Model's own step instant
  logic                    last_tick;
  logic                    in_move;
  logic                    done_due;
  logic [STEPS_WIDTH-1:0]  steps_left_ref;
  logic [PERIOD_WIDTH-1:0] gap;          // Cycles since start or last step
  logic [PERIOD_WIDTH-1:0] spacing;
  phase_index_t            position;
  logic                    dir_ref;
  microstep_t              mode_ref;
  coil_t                   coils;
  coil_t                   coils_expected;

  int unsigned reset_failures = 0;
  int unsigned spacing_failures = 0;
  int unsigned busy_failures = 0;
  int unsigned done_failures = 0;
  int unsigned coil_failures = 0;
  int unsigned pwm_failures = 0;
  int unsigned failures;         // Read by the testbench at the end

  function automatic phase_index_t next_position(phase_index_t pos, logic fwd,
                                                 microstep_t mode);
    int p;
    p = int'(pos);
    if (mode <= 3'd1) begin
      p = fwd ? p + 2 : p + 6;
      p = (p % 8) & 6;   // Full steps land on two-coil entries
    end else if (mode == 3'd2) begin
      p = fwd ? p + 1 : p + 7;
      p = p % 8;
    end
    return phase_index_t'(p);
  endfunction

  assign start_taken    = move_start && !in_move;
  assign tick_due       = in_move && (gap == spacing);
  assign last_tick      = tick_due && (steps_left_ref == STEPS_WIDTH'(1));
  assign coils          = {phase_a1, phase_a2, phase_b1, phase_b2};
  assign coils_expected = (in_move || hold) ? EXPECTED_COILS[position] : '0;
  assign failures       = reset_failures + spacing_failures + busy_failures
                        + done_failures + coil_failures + pwm_failures;

  always_ff @(posedge step) begin
    if (reset) begin
      in_move  <= 1'b0;
      done_due <= 1'b0;
      gap      <= '0;
      position <= '0;
    end else begin
      done_due <= (start_taken && (move_steps == '0)) || last_tick;
      if (start_taken) begin
        in_move        <= (move_steps != '0);
        steps_left_ref <= move_steps;
        spacing        <= (move_period < PERIOD_WIDTH'(2)) ? PERIOD_WIDTH'(2) : move_period;
        dir_ref        <= move_dir;
        mode_ref       <= microsteps;
        gap            <= PERIOD_WIDTH'(1);
      end else if (tick_due) begin
        in_move        <= !last_tick;
        steps_left_ref <= steps_left_ref - STEPS_WIDTH'(1);
        gap            <= PERIOD_WIDTH'(1);
        position       <= next_position(position, dir_ref, mode_ref);
      end else if (in_move) begin
        gap <= gap + PERIOD_WIDTH'(1);
      end
    end
  end

  // First cycle out of reset with hold low
  a_reset_state: assert property (@(posedge step)
    $past(reset) && !reset && !hold |-> !move_busy && !move_done && !step_out
      && (coils == '0) && !pwm_a && !pwm_b)
    else begin
      $error("Outputs not idle after reset");
      reset_failures = reset_failures + 1;
    end

  a_step_spacing: assert property (@(posedge step) disable iff (reset)
    step_out == tick_due)
    else begin
      $error("Step pulse missing or off its period");
      spacing_failures = spacing_failures + 1;
    end

  a_busy: assert property (@(posedge step) disable iff (reset) move_busy == in_move)
    else begin
      $error("Busy level does not match the move");
      busy_failures = busy_failures + 1;
    end

  a_done: assert property (@(posedge step) disable iff (reset) move_done == done_due)
    else begin
      $error("Done pulse missing or mistimed");
      done_failures = done_failures + 1;
    end

  a_coils: assert property (@(posedge step) disable iff (reset) coils == coils_expected)
    else begin
      $error("Coil pattern out of sequence");
      coil_failures = coil_failures + 1;
    end

  a_pwm: assert property (@(posedge step) disable iff (reset)
    (pwm_a == (coils_expected[3] | coils_expected[2]))
      && (pwm_b == (coils_expected[1] | coils_expected[0])))
    else begin
      $error("Bridge enable wrong for the coil pattern");
      pwm_failures = pwm_failures + 1;
    end

endmodule

bind stepper_axis stepper_axis_assert #(
  .STEPS_WIDTH  (STEPS_WIDTH),
  .PERIOD_WIDTH (PERIOD_WIDTH)
) stepper_axis_assert_inst (
  .step        (step),
  .reset       (reset),
  .move_start  (move_start),
  .move_steps  (move_steps),
  .move_period (move_period),
  .move_dir    (move_dir),
  .microsteps  (microsteps),
  .hold        (hold),
  .move_busy   (move_busy),
  .move_done   (move_done),
  .step_out    (step_out),
  .phase_a1    (phase_a1),
  .phase_a2    (phase_a2),
  .phase_b1    (phase_b1),
  .phase_b2    (phase_b2),
  .pwm_a       (pwm_a),
  .pwm_b       (pwm_b)
);

`default_nettype wire

/* sim/stepper_axis_tb.sv */
`default_nettype none

module stepper_axis_tb import motor_pkg::*; ();

  localparam int STEPS_WIDTH  = 16;
  localparam int PERIOD_WIDTH = 16;
  localparam int HALF_PERIOD  = 20;
  localparam int SEED         = 13096;
  localparam int RANDOM_MOVES = 40;
  localparam int WAIT_LIMIT   = 400;  // Longest random move is 12 x 9 cycles

  logic                    step = 1'b0;
  logic                    reset;
  logic                    move_start;
  logic [STEPS_WIDTH-1:0]  move_steps;
  logic [PERIOD_WIDTH-1:0] move_period;
  logic                    move_dir;
  microstep_t              microsteps;
  logic                    hold;
  logic                    move_busy;
  logic                    move_done;
  logic                    step_out;
  logic                    phase_a1;
  logic                    phase_a2;
  logic                    phase_b1;
  logic                    phase_b2;
  logic                    pwm_a;
  logic                    pwm_b;

  int   moves_run = 0;
  int   count_errors = 0;
  int   assert_failures = 0;
  logic timed_out = 1'b0;

  stepper_axis #(
    .STEPS_WIDTH  (STEPS_WIDTH),
    .PERIOD_WIDTH (PERIOD_WIDTH)
  ) stepper_axis_inst (
    .step        (step),
    .reset       (reset),
    .move_start  (move_start),
    .move_steps  (move_steps),
    .move_period (move_period),
    .move_dir    (move_dir),
    .microsteps  (microsteps),
    .hold        (hold),
    .move_busy   (move_busy),
    .move_done   (move_done),
    .step_out    (step_out),
    .phase_a1    (phase_a1),
    .phase_a2    (phase_a2),
    .phase_b1    (phase_b1),
    .phase_b2    (phase_b2),
    .pwm_a       (pwm_a),
    .pwm_b       (pwm_b)
  );

  always #HALF_PERIOD step = ~step;

  // Starts one move and counts its step pulses until done
  task automatic run_move(input int steps, input int period, input logic dir,
                          input int mode, input logic hold_level, input int poke_cycle);
    int cycles;
    int pulses;
    if (!timed_out) begin
      cycles      = 0;
      pulses      = 0;
      move_steps  = STEPS_WIDTH'(steps);
      move_period = PERIOD_WIDTH'(period);
      move_dir    = dir;
      microsteps  = microstep_t'(mode);
      hold        = hold_level;
      move_start  = 1'b1;
      @(negedge step);
      move_start = 1'b0;
      while (!move_done && (cycles < WAIT_LIMIT)) begin
        if (step_out) begin
          pulses++;
        end
        if ((cycles == poke_cycle) && move_busy) begin
          move_start = 1'b1;  // Must be dropped while busy
          move_steps = STEPS_WIDTH'(steps + 3);
        end else begin
          move_start = 1'b0;
        end
        cycles++;
        @(negedge step);
      end
      move_start = 1'b0;
      moves_run++;
      if (!move_done) begin
        $display("Timeout: no move_done within %0d cycles of move %0d", WAIT_LIMIT, moves_run);
        timed_out = 1'b1;
      end else if (pulses != steps) begin
        $display("Error at time %0t: move %0d gave %0d step pulses, %0d requested",
                 $time, moves_run, pulses, steps);
        count_errors++;
      end
      @(negedge step);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset       = 1'b1;
    move_start  = 1'b0;
    move_steps  = '0;
    move_period = '0;
    move_dir    = 1'b0;
    microsteps  = '0;
    hold        = 1'b0;
    repeat (2) @(negedge step);
    reset = 1'b0;
    @(negedge step);

    run_move(5, 3, 1'b1, 0, 1'b0, -1);  // Full step forward from reset
    run_move(4, 2, 1'b0, 1, 1'b1, -1);  // Full step reverse and held after
    run_move(3, 4, 1'b1, 2, 1'b1, -1);  // Half step ending on an odd entry
    run_move(2, 0, 1'b0, 0, 1'b0, -1);  // Period clamp from 0
    run_move(6, 1, 1'b0, 2, 1'b1, -1);
    run_move(3, 5, 1'b1, 5, 1'b1, -1);  // Hold mode keeps the pattern
    run_move(0, 4, 1'b1, 2, 1'b0, -1);
    run_move(6, 3, 1'b1, 0, 1'b0, 2);   // Start during the move

    for (int i = 0; i < RANDOM_MOVES; i++) begin
      run_move(int'($urandom % 13), 2 + int'($urandom % 8), logic'($urandom % 2),
               int'($urandom % 8), logic'($urandom % 2),
               (($urandom % 4) == 0) ? 3 : -1);
      hold = logic'($urandom % 2);
      @(negedge step);
    end

    assert_failures = stepper_axis_inst.stepper_axis_assert_inst.failures;
    $display("Moves %0d, step count errors %0d, assertion failures %0d, timeouts %0d",
             moves_run, count_errors, assert_failures, timed_out);
    if ((count_errors == 0) && (assert_failures == 0) && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stepper_axis.f */
logic/motor_pkg.sv
logic/move_pkg.sv
logic/move_control.sv
logic/step_timer.sv
logic/dual_hbridge.sv
logic/stepper_axis.sv
sim/stepper_axis_assert.sv
sim/stepper_axis_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the stepper axis testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module stepper_axis_tb \
  -f stepper_axis.f

status=0
output=$(./obj_dir/Vstepper_axis_tb +verilator+error+limit+1000) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -Fqx '** PASS **'; then
  exit 0
fi
exit 1
